// ==== include/wb_defs.svh ====
// Writeback stage widths and constants

`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// Datapath
`define WB_XLEN     32              // Data and address word width
`define WB_REG_AW   5               // GPR index width
`define WB_CSR_AW   12              // CSR address width

// --------------------
// Reset state

`define WB_PC_RESET 32'h8000_0000   // First fetch address

`endif

// ==== hdl/wb_types_pkg.sv ====
// Writeback stage vector types

`default_nettype none

`include "wb_defs.svh"

package wb_types_pkg;

    typedef logic [`WB_XLEN-1:0]   word_t;      // Data or address word
    typedef logic [`WB_REG_AW-1:0] reg_addr_t;  // GPR index
    typedef logic [`WB_CSR_AW-1:0] csr_addr_t;  // CSR address
    typedef logic [5:0]            cause_t;     // mcause code
    typedef logic [4:0]            fu_sel_t;    // One-hot unit select
    typedef logic [4:0]            uop_t;       // Micro-op
    typedef logic [1:0]            size_t;      // Size in half-words

endpackage

`default_nettype wire

// ==== hdl/wb_op_pkg.sv ====
// Writeback stage op and trap encodings

`default_nettype none

package wb_op_pkg;

    // --------------------
    // Unit select bit positions
    localparam int FU_ALU = 0;
    localparam int FU_MUL = 1;
    localparam int FU_LSU = 2;
    localparam int FU_CFU = 3;
    localparam int FU_CSR = 4;

    // --------------------
    // LSU micro-op fields
    localparam int         LSU_SIGNED = 0;      // Sign extend load data
    localparam logic [1:0] LSU_BYTE   = 2'd1;   // Width field, bits 2..1
    localparam logic [1:0] LSU_HALF   = 2'd2;
    localparam logic [1:0] LSU_WORD   = 2'd3;
    localparam int         LSU_LOAD   = 3;
    localparam int         LSU_STORE  = 4;

    // CSR micro-op bits
    localparam int CSR_READ  = 3;
    localparam int CSR_WRITE = 2;
    localparam int CSR_SET   = 1;
    localparam int CSR_CLEAR = 0;

    // --------------------
    // CFU codes, compared whole
    localparam wb_types_pkg::uop_t CFU_TAKEN  = 5'd1;   // Taken branch
    localparam wb_types_pkg::uop_t CFU_JALI   = 5'd2;   // Direct jump and link
    localparam wb_types_pkg::uop_t CFU_JALR   = 5'd3;   // Indirect jump and link
    localparam wb_types_pkg::uop_t CFU_EBREAK = 5'd4;
    localparam wb_types_pkg::uop_t CFU_ECALL  = 5'd5;
    localparam wb_types_pkg::uop_t CFU_MRET   = 5'd6;

    // Synchronous trap causes
    localparam wb_types_pkg::cause_t TRAP_IOPCODE  = 6'd2;  // Illegal opcode
    localparam wb_types_pkg::cause_t TRAP_BREAKPT  = 6'd3;
    localparam wb_types_pkg::cause_t TRAP_LDACCESS = 6'd5;  // Load access fault
    localparam wb_types_pkg::cause_t TRAP_STACCESS = 6'd7;  // Store access fault
    localparam wb_types_pkg::cause_t TRAP_ECALLM   = 6'd11; // ECALL from M mode

endpackage

`default_nettype wire

// ==== hdl/wb_load_align.sv ====
// Load data alignment

`timescale 1ns/1ps
`default_nettype none

module wb_load_align (
    input  wb_types_pkg::word_t mem_rdata,  // Raw bus read data
    input  logic [1:0]          addr_lo,    // Byte offset in word
    input  logic [3:0]          strb,       // Byte strobes from memory stage
    input  wb_types_pkg::uop_t  uop,        // LSU micro-op
    output wb_types_pkg::word_t load_data   // Aligned, extended result
);

    logic       is_byte;
    logic       is_half;
    logic       is_word;
    logic       is_signed;
    logic [7:0] b0;
    logic [7:0] b1;
    logic [15:0] h1;

    assign is_byte   = uop[2:1] == wb_op_pkg::LSU_BYTE;
    assign is_half   = uop[2:1] == wb_op_pkg::LSU_HALF;
    assign is_word   = uop[2:1] == wb_op_pkg::LSU_WORD;
    assign is_signed = uop[wb_op_pkg::LSU_SIGNED];

    // Lowest byte, picked by offset
    assign b0 = {8{strb[0]}}                     & mem_rdata[7:0]   |
                {8{is_byte && addr_lo == 2'b01}} & mem_rdata[15:8]  |
                {8{is_byte && addr_lo == 2'b10}} & mem_rdata[23:16] |
                {8{is_half && addr_lo[1]}}       & mem_rdata[23:16] |
                {8{is_byte && addr_lo == 2'b11}} & mem_rdata[31:24];

    // Second byte, data or sign of a byte load
    assign b1 = {8{is_byte && is_signed}}    & {8{b0[7]}}       |
                {8{is_half && !addr_lo[1]}}  & mem_rdata[15:8]  |
                {8{is_word}}                 & mem_rdata[15:8]  |
                {8{is_half && addr_lo[1]}}   & mem_rdata[31:24];

    assign h1 = {16{(is_byte || is_half) && is_signed}} & {16{b1[7]}} |
                {16{is_word}}                          & mem_rdata[31:16];

    assign load_data = {h1, b1, b0};

    // Width field must be set on any load reaching here
    always_comb begin
        if (uop[wb_op_pkg::LSU_LOAD]) begin
            assert (uop[2:1] != 2'b00) else $error("load with zero width field");
        end
    end

endmodule

`default_nettype wire

// ==== hdl/wb_lsu_resp.sv ====
// Data memory response tracking

`timescale 1ns/1ps
`default_nettype none

module wb_lsu_resp (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  logic                fu_lsu,         // LSU op in stage
    input  wb_types_pkg::uop_t  uop,
    input  wb_types_pkg::word_t opr_a,          // Low 4 bits are strobes
    input  wb_types_pkg::word_t opr_b,          // Access address
    input  logic                progress,
    input  logic                dmem_recv,
    input  logic                dmem_error,
    input  wb_types_pkg::word_t dmem_rdata,
    output logic                dmem_ack,       // Response expected
    output logic                lsu_busy,       // Still waiting on memory
    output logic                lsu_load,
    output logic                lsu_gpr_wen,
    output wb_types_pkg::word_t lsu_gpr_wdata,
    output logic                lsu_load_err,   // Held until progress
    output logic                lsu_store_err
);

    logic               rsp_seen;   // Response already taken
    logic               err_seen;   // That response had an error
    logic               rsp_now;
    logic               bus_err;
    logic               lsu_store;
    wb_types_pkg::uop_t align_uop;

    assign lsu_load  = fu_lsu && uop[wb_op_pkg::LSU_LOAD];
    assign lsu_store = fu_lsu && uop[wb_op_pkg::LSU_STORE];

    assign dmem_ack = fu_lsu && !rsp_seen;
    assign rsp_now  = dmem_recv && dmem_ack;
    assign lsu_busy = fu_lsu && !(rsp_seen || rsp_now);

    // --------------------
    // Response and error flags live for one instruction
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_seen <= 1'b0;
            err_seen <= 1'b0;
        end else if (progress) begin
            rsp_seen <= 1'b0;
            err_seen <= 1'b0;
        end else begin
            rsp_seen <= rsp_seen || rsp_now;
            err_seen <= err_seen || (rsp_now && dmem_error);
        end
    end

    assign bus_err       = err_seen || (rsp_now && dmem_error);
    assign lsu_load_err  = bus_err && lsu_load;
    assign lsu_store_err = bus_err && lsu_store;

    // Write only in the cycle the clean response lands
    assign lsu_gpr_wen = lsu_load && rsp_now && !dmem_error;

    assign align_uop = {5{fu_lsu}} & uop;   // Quiet for non-LSU ops

    wb_load_align u_align (
        .mem_rdata (dmem_rdata),
        .addr_lo   (opr_b[1:0]),
        .strb      (opr_a[3:0]),
        .uop       (align_uop),
        .load_data (lsu_gpr_wdata)
    );

    // Response flag belongs to the LSU op still in the stage
    assert property (@(posedge g_clk) disable iff (!g_resetn) rsp_seen |-> fu_lsu)
        else $error("response flag outlived its LSU op");

endmodule

`default_nettype wire

// ==== hdl/wb_csr_access.sv ====
// CSR access issue

`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module wb_csr_access (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    fu_csr,
    input  wb_types_pkg::uop_t      uop,
    input  wb_types_pkg::word_t     opr_a,          // Write data
    input  wb_types_pkg::word_t     opr_b,          // CSR address in low bits
    input  logic                    progress,
    input  wb_types_pkg::word_t     csr_rdata,
    output logic                    csr_en,         // One strobe per instruction
    output logic                    csr_wr,
    output logic                    csr_wr_set,
    output logic                    csr_wr_clr,
    output wb_types_pkg::csr_addr_t csr_addr,
    output wb_types_pkg::word_t     csr_wdata,
    output logic                    csr_gpr_wen,
    output wb_types_pkg::word_t     csr_gpr_wdata
);

    logic csr_done;     // Access issued for the instruction in stage

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            csr_done <= 1'b0;
        end else begin
            csr_done <= !progress && (csr_done || csr_en);
        end
    end

    assign csr_en     = fu_csr && !csr_done;
    assign csr_wr     = fu_csr && uop[wb_op_pkg::CSR_WRITE];
    assign csr_wr_set = fu_csr && uop[wb_op_pkg::CSR_SET];
    assign csr_wr_clr = fu_csr && uop[wb_op_pkg::CSR_CLEAR];
    assign csr_addr   = opr_b[`WB_CSR_AW-1:0];
    assign csr_wdata  = opr_a;

    // Read data lands in the GPR alongside the strobe
    assign csr_gpr_wen   = csr_en && uop[wb_op_pkg::CSR_READ];
    assign csr_gpr_wdata = csr_rdata;

    // Done flag belongs to the CSR op still in the stage
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        csr_done |-> fu_csr)
        else $error("CSR done flag outlived its instruction");

endmodule

`default_nettype wire

// ==== hdl/wb_ctrl_flow.sv ====
// Control flow changes, traps and stage PC

`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module wb_ctrl_flow (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    fu_cfu,
    input  wb_types_pkg::uop_t      uop,
    input  logic                    s4_trap,        // Trap flagged upstream
    input  wb_types_pkg::reg_addr_t s4_rd,
    input  wb_types_pkg::size_t     s4_size,
    input  wb_types_pkg::word_t     opr_a,          // Jump or branch target
    input  logic                    progress,
    input  logic                    csr_error,      // Already qualified by CSR op
    input  logic                    lsu_load_err,
    input  logic                    lsu_store_err,
    input  wb_types_pkg::word_t     csr_mepc,
    input  wb_types_pkg::word_t     csr_mtvec,
    input  logic                    cf_ack,
    output logic                    cf_req,
    output wb_types_pkg::word_t     cf_target,
    output logic                    cfu_busy,
    output logic                    cfu_gpr_wen,
    output wb_types_pkg::word_t     cfu_gpr_wdata,
    output logic                    exec_mret,      // Pulse at MRET retire
    output logic                    trap_cpu,
    output wb_types_pkg::cause_t    trap_cause,
    output wb_types_pkg::word_t     s4_pc
);

    wb_types_pkg::word_t n_s4_pc;
    logic cfu_taken;
    logic cfu_link;
    logic cfu_ebreak;
    logic cfu_ecall;
    logic cfu_mret;
    logic cfu_done;     // Change completed, stage still stalled
    logic finish_now;

    // --------------------
    // Decode
    assign cfu_link   = fu_cfu && (uop == wb_op_pkg::CFU_JALI || uop == wb_op_pkg::CFU_JALR);
    assign cfu_taken  = cfu_link || (fu_cfu && uop == wb_op_pkg::CFU_TAKEN);
    assign cfu_ebreak = fu_cfu && uop == wb_op_pkg::CFU_EBREAK;
    assign cfu_ecall  = fu_cfu && uop == wb_op_pkg::CFU_ECALL;
    assign cfu_mret   = fu_cfu && uop == wb_op_pkg::CFU_MRET;

    assign trap_cpu = cfu_ebreak || cfu_ecall || s4_trap || csr_error ||
                      lsu_load_err || lsu_store_err;

    // --------------------
    // Request and target
    assign cf_req = (cfu_taken || cfu_mret || trap_cpu) && !cfu_done;

    assign cf_target = trap_cpu ? csr_mtvec :
                       ({`WB_XLEN{cfu_taken}} & opr_a) | ({`WB_XLEN{cfu_mret}} & csr_mepc);

    assign finish_now = cf_req && cf_ack;
    assign cfu_busy   = fu_cfu && (cfu_taken || cfu_mret || cfu_ebreak || cfu_ecall) &&
                        !(cfu_done || finish_now);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cfu_done <= 1'b0;
        end else begin
            cfu_done <= !progress && (cfu_done || finish_now);
        end
    end

    assign exec_mret = cfu_mret && progress;

    // Link register gets the fall-through PC
    assign cfu_gpr_wen   = cfu_link && progress;
    assign cfu_gpr_wdata = n_s4_pc;

    assign trap_cause = lsu_load_err  ? wb_op_pkg::TRAP_LDACCESS :
                        lsu_store_err ? wb_op_pkg::TRAP_STACCESS :
                        cfu_ebreak    ? wb_op_pkg::TRAP_BREAKPT  :
                        cfu_ecall     ? wb_op_pkg::TRAP_ECALLM   :
                        csr_error     ? wb_op_pkg::TRAP_IOPCODE  :
                                        {1'b0, s4_rd};

    // --------------------
    // Stage PC
    assign n_s4_pc = s4_pc + {{(`WB_XLEN-3){1'b0}}, s4_size, 1'b0};

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            s4_pc <= `WB_PC_RESET;
        end else if (finish_now) begin
            s4_pc <= cf_target;     // Change wins over step
        end else if (progress) begin
            s4_pc <= n_s4_pc;
        end
    end

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf_req && !cf_ack |=> cf_req && $stable(cf_target))
        else $error("cf_target moved while request pending");

endmodule

`default_nettype wire

// ==== hdl/frv_writeback.sv ====
// Writeback stage top

`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module frv_writeback (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_types_pkg::reg_addr_t s4_rd,
    input  wb_types_pkg::word_t     s4_opr_a,
    input  wb_types_pkg::word_t     s4_opr_b,
    input  wb_types_pkg::uop_t      s4_uop,
    input  wb_types_pkg::fu_sel_t   s4_fu,          // One-hot unit
    input  logic                    s4_trap,
    input  wb_types_pkg::size_t     s4_size,
    input  logic [31:0]             s4_instr,
    output logic                    s4_busy,
    input  logic                    s4_valid,
    output wb_types_pkg::reg_addr_t fwd_s4_rd,
    output wb_types_pkg::word_t     fwd_s4_wdata,
    output logic                    fwd_s4_load,
    output logic                    fwd_s4_csr,
    output logic                    gpr_wen,
    output wb_types_pkg::reg_addr_t gpr_rd,
    output wb_types_pkg::word_t     gpr_wdata,
    output logic                    trap_cpu,
    output wb_types_pkg::cause_t    trap_cause,
    output wb_types_pkg::word_t     trap_pc,
    output logic                    exec_mret,
    input  wb_types_pkg::word_t     csr_mepc,
    input  wb_types_pkg::word_t     csr_mtvec,
    output wb_types_pkg::word_t     trs_pc,
    output logic [31:0]             trs_instr,
    output logic                    trs_valid,
    output logic                    csr_en,
    output logic                    csr_wr,
    output logic                    csr_wr_set,
    output logic                    csr_wr_clr,
    output wb_types_pkg::csr_addr_t csr_addr,
    output wb_types_pkg::word_t     csr_wdata,
    input  wb_types_pkg::word_t     csr_rdata,
    input  logic                    csr_error,
    output logic                    cf_req,
    output wb_types_pkg::word_t     cf_target,
    input  logic                    cf_ack,
    output logic                    hold_lsu_req,   // Hold off new LSU requests
    input  logic                    dmem_recv,
    output logic                    dmem_ack,
    input  logic                    dmem_error,
    input  wb_types_pkg::word_t     dmem_rdata
);

    logic fu_alu;
    logic fu_mul;
    logic fu_lsu;
    logic fu_cfu;
    logic fu_csr;
    logic progress;     // Instruction retires this cycle
    logic lsu_busy;
    logic lsu_load;
    logic lsu_gpr_wen;
    logic lsu_load_err;
    logic lsu_store_err;
    logic csr_gpr_wen;
    logic cfu_busy;
    logic cfu_gpr_wen;
    logic alu_gpr_wen;
    logic mul_gpr_wen;
    wb_types_pkg::word_t lsu_gpr_wdata;
    wb_types_pkg::word_t csr_gpr_wdata;
    wb_types_pkg::word_t cfu_gpr_wdata;
    wb_types_pkg::word_t s4_pc;

    // --------------------
    // Unit decode and stall
    assign fu_alu = s4_fu[wb_op_pkg::FU_ALU];
    assign fu_mul = s4_fu[wb_op_pkg::FU_MUL];
    assign fu_lsu = s4_fu[wb_op_pkg::FU_LSU];
    assign fu_cfu = s4_fu[wb_op_pkg::FU_CFU];
    assign fu_csr = s4_fu[wb_op_pkg::FU_CSR];

    assign s4_busy      = cfu_busy || (cf_req && !cf_ack) || lsu_busy;
    assign progress     = s4_valid && !s4_busy;
    assign hold_lsu_req = cf_req || lsu_busy;

    wb_lsu_resp u_lsu_resp (
        .g_clk, .g_resetn, .fu_lsu,
        .uop (s4_uop), .opr_a (s4_opr_a), .opr_b (s4_opr_b), .progress,
        .dmem_recv, .dmem_error, .dmem_rdata, .dmem_ack,
        .lsu_busy, .lsu_load, .lsu_gpr_wen, .lsu_gpr_wdata,
        .lsu_load_err, .lsu_store_err
    );

    wb_csr_access u_csr_access (
        .g_clk, .g_resetn, .fu_csr,
        .uop (s4_uop), .opr_a (s4_opr_a), .opr_b (s4_opr_b), .progress,
        .csr_rdata, .csr_en, .csr_wr, .csr_wr_set, .csr_wr_clr,
        .csr_addr, .csr_wdata, .csr_gpr_wen, .csr_gpr_wdata
    );

    wb_ctrl_flow u_ctrl_flow (
        .g_clk, .g_resetn, .fu_cfu,
        .uop (s4_uop), .s4_trap, .s4_rd, .s4_size, .opr_a (s4_opr_a), .progress,
        .csr_error (csr_error && fu_csr),   // Ignore stray errors
        .lsu_load_err, .lsu_store_err, .csr_mepc, .csr_mtvec, .cf_ack,
        .cf_req, .cf_target, .cfu_busy, .cfu_gpr_wen, .cfu_gpr_wdata,
        .exec_mret, .trap_cpu, .trap_cause, .s4_pc
    );

    // --------------------
    // GPR write merge where ALU and MUL pass opr_a
    assign alu_gpr_wen = fu_alu && progress;
    assign mul_gpr_wen = fu_mul && progress;

    assign gpr_wen = !trap_cpu &&
                     (alu_gpr_wen || mul_gpr_wen || lsu_gpr_wen || csr_gpr_wen || cfu_gpr_wen);

    assign gpr_wdata = {`WB_XLEN{alu_gpr_wen || mul_gpr_wen}} & s4_opr_a      |
                       {`WB_XLEN{lsu_gpr_wen}}                & lsu_gpr_wdata |
                       {`WB_XLEN{csr_gpr_wen}}                & csr_gpr_wdata |
                       {`WB_XLEN{cfu_gpr_wen}}                & cfu_gpr_wdata;
    assign gpr_rd    = s4_rd;

    assign fwd_s4_rd    = s4_rd;
    assign fwd_s4_wdata = gpr_wdata;
    assign fwd_s4_load  = lsu_load;     // Data may not be here yet
    assign fwd_s4_csr   = fu_csr;

    // Trap PC and trace
    assign trap_pc   = s4_pc;
    assign trs_pc    = s4_pc;
    assign trs_instr = s4_instr;
    assign trs_valid = |s4_size && progress;

endmodule

`default_nettype wire

// ==== bench/tb_writeback.sv ====
// Writeback stage testbench

`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module tb_writeback;

    localparam int MAX_LINES = 64;
    localparam wb_types_pkg::word_t MTVEC = 32'h8000_0100;
    localparam wb_types_pkg::word_t MEPC  = 32'h8000_2000;

    logic g_clk;
    logic g_resetn;
    wb_types_pkg::reg_addr_t s4_rd;
    wb_types_pkg::word_t s4_opr_a;
    wb_types_pkg::word_t s4_opr_b;
    wb_types_pkg::uop_t s4_uop;
    wb_types_pkg::fu_sel_t s4_fu;
    logic s4_trap;
    wb_types_pkg::size_t s4_size;
    logic [31:0] s4_instr;
    logic s4_busy;
    logic s4_valid;
    wb_types_pkg::reg_addr_t fwd_s4_rd;
    wb_types_pkg::word_t fwd_s4_wdata;
    logic fwd_s4_load;
    logic fwd_s4_csr;
    logic gpr_wen;
    wb_types_pkg::reg_addr_t gpr_rd;
    wb_types_pkg::word_t gpr_wdata;
    logic trap_cpu;
    wb_types_pkg::cause_t trap_cause;
    wb_types_pkg::word_t trap_pc;
    logic exec_mret;
    wb_types_pkg::word_t trs_pc;
    logic [31:0] trs_instr;
    logic trs_valid;
    logic csr_en;
    logic csr_wr;
    logic csr_wr_set;
    logic csr_wr_clr;
    wb_types_pkg::csr_addr_t csr_addr;
    wb_types_pkg::word_t csr_wdata;
    wb_types_pkg::word_t csr_rdata;
    logic csr_error;
    logic cf_req;
    wb_types_pkg::word_t cf_target;
    logic cf_ack;
    logic hold_lsu_req;
    logic dmem_recv;
    logic dmem_ack;
    logic dmem_error;
    wb_types_pkg::word_t dmem_rdata;

    // One stimulus table entry per file line
    wb_types_pkg::word_t tbl [MAX_LINES][17];
    int n_lines = 0;
    int errors = 0;
    int checks = 0;
    logic [15:0] lfsr = 16'd17585;

    frv_writeback UUT (.*, .csr_mepc (MEPC), .csr_mtvec (MTVEC));

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;
    end

    // --------------------
    // Helpers
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // Galois form
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int k = 0; k < n; k++) begin
            val = (val << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);     // One step per bit
        end
    endtask

    task automatic check_value(input string name, input wb_types_pkg::word_t exp,
                               input wb_types_pkg::word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic load_stimulus();
        int fd;
        int got;
        string line;
        fd = $fopen("bench/wb_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file bench/wb_stimulus.txt");
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                got = $fgets(line, fd);
                if (got > 1 && line[0] != "#") begin
                    got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        tbl[n_lines][0], tbl[n_lines][1], tbl[n_lines][2], tbl[n_lines][3],
                        tbl[n_lines][4], tbl[n_lines][5], tbl[n_lines][6], tbl[n_lines][7],
                        tbl[n_lines][8], tbl[n_lines][9], tbl[n_lines][10], tbl[n_lines][11],
                        tbl[n_lines][12], tbl[n_lines][13], tbl[n_lines][14],
                        tbl[n_lines][15], tbl[n_lines][16]);
                    if (got == 17) n_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    // --------------------
    // Run one instruction until it retires
    task automatic run_instr(input int i, inout wb_types_pkg::word_t ref_pc);
        int cyc;
        int mem_dly;
        int ack_dly;
        int exp_cyc;
        int wen_cnt;
        int en_cnt;
        int mret_cnt;
        logic done;
        logic req_now;
        logic is_lsu;
        logic is_csr;
        logic is_link;
        wb_types_pkg::word_t exp_wdata;
        string tn;
        tn = $sformatf("instr %0d", i);
        take_bits(2, mem_dly);
        take_bits(2, ack_dly);
        s4_fu      = tbl[i][0][4:0];
        s4_uop     = tbl[i][1][4:0];
        s4_rd      = tbl[i][2][4:0];
        s4_opr_a   = tbl[i][3];
        s4_opr_b   = tbl[i][4];
        s4_size    = tbl[i][5][1:0];
        s4_trap    = tbl[i][6][0];
        csr_rdata  = tbl[i][7];
        csr_error  = tbl[i][8][0];
        dmem_rdata = tbl[i][9];
        dmem_error = tbl[i][10][0];
        s4_instr   = 32'h0000_0013 + i;
        s4_valid   = 1'b1;
        is_lsu  = s4_fu[wb_op_pkg::FU_LSU];
        is_csr  = s4_fu[wb_op_pkg::FU_CSR];
        is_link = s4_fu[wb_op_pkg::FU_CFU] && (s4_uop == 5'd2 || s4_uop == 5'd3);
        exp_wdata = is_link ? ref_pc + {s4_size, 1'b0} : tbl[i][12];  // Link gets next PC
        // Retire at the response, later if a request waits for its ack
        exp_cyc = (is_lsu ? mem_dly : 0) + (tbl[i][13][0] ? ack_dly : 0);
        cyc = 0;
        done = 0;
        wen_cnt = 0;
        en_cnt = 0;
        mret_cnt = 0;
        while (!done) begin
            dmem_recv = is_lsu && cyc >= mem_dly;
            cf_ack = cyc >= (is_lsu ? mem_dly : 0) + ack_dly;   // Counted from request
            #2;
            req_now = tbl[i][13][0] && cyc >= (is_lsu ? mem_dly : 0);
            check_value({tn, " cf_req"}, req_now, cf_req);
            if (cf_req) check_value({tn, " cf_target"}, tbl[i][14], cf_target);
            check_value({tn, " dmem_ack"}, is_lsu && cyc <= mem_dly, dmem_ack);
            check_value({tn, " hold_lsu_req"}, req_now || (is_lsu && cyc < mem_dly),
                        hold_lsu_req);
            check_value({tn, " fwd_s4_rd"}, s4_rd, fwd_s4_rd);
            check_value({tn, " fwd_s4_load"}, is_lsu && s4_uop[wb_op_pkg::LSU_LOAD],
                        fwd_s4_load);
            check_value({tn, " fwd_s4_csr"}, is_csr, fwd_s4_csr);
            if (csr_en) begin
                en_cnt++;
                check_value({tn, " csr_addr"}, s4_opr_b[`WB_CSR_AW-1:0], csr_addr);
                check_value({tn, " csr_wdata"}, s4_opr_a, csr_wdata);
                check_value({tn, " csr_wr"}, s4_uop[wb_op_pkg::CSR_WRITE], csr_wr);
                check_value({tn, " csr_wr_set"}, s4_uop[wb_op_pkg::CSR_SET], csr_wr_set);
                check_value({tn, " csr_wr_clr"}, s4_uop[wb_op_pkg::CSR_CLEAR], csr_wr_clr);
            end
            if (exec_mret) mret_cnt++;
            if (gpr_wen) begin
                wen_cnt++;
                check_value({tn, " gpr_rd"}, s4_rd, gpr_rd);
                check_value({tn, " gpr_wdata"}, exp_wdata, gpr_wdata);
                check_value({tn, " fwd_s4_wdata"}, exp_wdata, fwd_s4_wdata);
            end
            if (s4_valid && !s4_busy) begin     // Progress
                done = 1;
                check_value({tn, " retire cycle"}, exp_cyc, cyc);
                check_value({tn, " trap_cpu"}, tbl[i][15], trap_cpu);
                if (tbl[i][15][0]) check_value({tn, " trap_cause"}, tbl[i][16], trap_cause);
                check_value({tn, " trs_pc"}, ref_pc, trs_pc);
                check_value({tn, " trap_pc"}, ref_pc, trap_pc);
                check_value({tn, " trs_instr"}, s4_instr, trs_instr);
                check_value({tn, " trs_valid"}, s4_size != 0, trs_valid);
                ref_pc = tbl[i][13][0] ? tbl[i][14] : ref_pc + {s4_size, 1'b0};
            end
            cyc++;
            @(negedge g_clk);
        end
        check_value({tn, " gpr writes"}, tbl[i][11], wen_cnt);
        check_value({tn, " csr_en pulses"}, is_csr, en_cnt);
        check_value({tn, " exec_mret pulses"},
                    s4_fu[wb_op_pkg::FU_CFU] && s4_uop == wb_op_pkg::CFU_MRET, mret_cnt);
    endtask

    // --------------------
    // Main sequence
    initial begin
        wb_types_pkg::word_t ref_pc;
        g_resetn = 1'b0;
        s4_valid = 1'b0;
        s4_fu = '0;
        s4_uop = '0;
        s4_rd = '0;
        s4_opr_a = '0;
        s4_opr_b = '0;
        s4_trap = 1'b0;
        s4_size = '0;
        s4_instr = '0;
        csr_rdata = '0;
        csr_error = 1'b0;
        cf_ack = 1'b0;
        dmem_recv = 1'b0;
        dmem_error = 1'b0;
        dmem_rdata = '0;
        ref_pc = `WB_PC_RESET;
        load_stimulus();
        repeat (5) @(negedge g_clk);
        g_resetn = 1'b1;
        for (int i = 0; i < n_lines; i++) begin
            run_instr(i, ref_pc);
        end
        s4_valid = 1'b0;
        s4_fu = '0;
        $display("Instructions: %0d, checks: %0d, errors: %0d", n_lines, checks, errors);
        if (errors == 0 && n_lines > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Ten cycles per instruction plus reset
    initial begin
        wait (n_lines > 0);
        repeat ((n_lines + 1) * 10) @(posedge g_clk);
        $display("Timeout: the stage did not retire all instructions in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/wb_stimulus.txt ====
# fu uop rd opr_a opr_b size trap csr_rdata csr_err mem_rdata mem_err (hex inputs)
# exp_wen exp_wdata exp_req exp_target exp_trap exp_cause (link wdata comes from the PC)
01 00 05 12345678 00000000 2 0 00000000 0 00000000 0 1 12345678 0 00000000 0 00
02 00 1f cafef00d 00000000 2 0 00000000 0 00000000 0 1 cafef00d 0 00000000 0 00
01 00 05 11111111 00000000 2 1 00000000 0 00000000 0 0 00000000 1 80000100 1 05
01 00 03 00000abc 00000000 1 0 00000000 0 00000000 0 1 00000abc 0 00000000 0 00
04 0b 0a 00000001 00001000 2 0 00000000 0 8a7bc6f5 0 1 fffffff5 0 00000000 0 00
04 0a 0a 00000002 00001001 2 0 00000000 0 8a7bc6f5 0 1 000000c6 0 00000000 0 00
04 0b 0a 00000004 00001002 2 0 00000000 0 8a7bc6f5 0 1 0000007b 0 00000000 0 00
04 0b 0a 00000008 00001003 2 0 00000000 0 8a7bc6f5 0 1 ffffff8a 0 00000000 0 00
04 0a 0a 00000008 00001003 2 0 00000000 0 8a7bc6f5 0 1 0000008a 0 00000000 0 00
04 0c 0b 00000003 00001000 2 0 00000000 0 8a7bc6f5 0 1 0000c6f5 0 00000000 0 00
04 0d 0b 00000003 00001000 2 0 00000000 0 8a7bc6f5 0 1 ffffc6f5 0 00000000 0 00
04 0d 0b 0000000c 00001002 2 0 00000000 0 8a7bc6f5 0 1 ffff8a7b 0 00000000 0 00
04 0e 0c 0000000f 00001000 2 0 00000000 0 8a7bc6f5 0 1 8a7bc6f5 0 00000000 0 00
04 16 00 0000000f 00001000 2 0 00000000 0 00000000 0 0 00000000 0 00000000 0 00
04 0e 0a 0000000f 00001000 2 0 00000000 0 deadbeef 1 0 00000000 1 80000100 1 05
04 16 00 0000000f 00001004 2 0 00000000 0 00000000 1 0 00000000 1 80000100 1 07
08 01 00 80000400 00000000 2 0 00000000 0 00000000 0 0 00000000 1 80000400 0 00
08 02 01 80000800 00000000 2 0 00000000 0 00000000 0 1 00000000 1 80000800 0 00
08 03 01 80000900 00000000 1 0 00000000 0 00000000 0 1 00000000 1 80000900 0 00
10 08 07 00000000 00000300 2 0 13572468 0 00000000 0 1 13572468 0 00000000 0 00
10 08 07 00000000 00000fff 2 0 00000000 1 00000000 0 0 00000000 1 80000100 1 02
10 04 00 00000055 00000300 2 0 00000000 0 00000000 0 0 00000000 0 00000000 0 00
08 05 00 00000000 00000000 2 0 00000000 0 00000000 0 0 00000000 1 80000100 1 0b
08 04 00 00000000 00000000 2 0 00000000 0 00000000 0 0 00000000 1 80000100 1 03
08 06 00 00000000 00000000 2 0 00000000 0 00000000 0 0 00000000 1 80002000 0 00
01 00 02 0f0f0f0f 00000000 2 0 00000000 0 00000000 0 1 0f0f0f0f 0 00000000 0 00

// ==== tb.f ====
+incdir+include
hdl/wb_types_pkg.sv
hdl/wb_op_pkg.sv
hdl/wb_load_align.sv
hdl/wb_lsu_resp.sv
hdl/wb_csr_access.sv
hdl/wb_ctrl_flow.sv
hdl/frv_writeback.sv
bench/tb_writeback.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the writeback stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_writeback --Mdir obj_dir -o tb_writeback_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_writeback_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation run returned an error, see sim.log"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0
